//--- dv/regs900_checker.sv
// watches the apb bus after reset; keeps its own register model and counts mismatches
`timescale 1ns/1ps
module regs900_checker (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [regs900_pkg::ADDR_W-1:0] paddr,
    input  regs900_pkg::word_t             pwdata,
    input  regs900_pkg::word_t             prdata,
    input  logic                           pready,
    input  logic                           pslverr,
    output int                             value_errs,
    output int                             proto_errs,
    output int                             reads,
    output int                             writes
);
    import regs900_pkg::*;

    word_t      acc [16];                            // bank * 4 + register
    word_t      ptr [4];
    logic [2:0] imask;
    logic [1:0] rfp;
    logic [5:0] flg;                                 // s z h v n c
    logic [5:0] alt;
    int         waits;

    function automatic logic [7:0] fbyte(logic [5:0] f);
        return {f[5], f[4], 1'b0, f[3], 1'b0, f[2], f[1], f[0]};
    endfunction

    function automatic logic [15:0] sr_word();
        return {1'b1, imask, 2'b10, rfp, fbyte(flg)};
    endfunction

    function automatic logic legal_xfer(reg_code_t code, size_t sz, logic wr, word_t d);
        logic lane_ok;
        case (sz)
            SZ_BYTE: lane_ok = 1'b1;
            SZ_WORD: lane_ok = !code[0];             // even lane only
            SZ_LONG: lane_ok = (code[1:0] == 2'd0);
            default: return 1'b0;                    // size 3
        endcase
        if (code == CODE_FX) return (sz != SZ_LONG) && !(wr && d != '0);
        if (code == CODE_SR) return sz != SZ_LONG;
        if (code[7] && code[6]) return 1'b0;         // unknown special
        if (code[7] && code[5:4] != 2'd0) return 1'b0;
        return lane_ok;
    endfunction

    function automatic word_t lane_merge(word_t old, size_t sz, logic [1:0] lane, word_t d);
        word_t v;
        v = old;
        case (sz)
            SZ_BYTE: v[8*lane +: 8] = d[7:0];
            SZ_WORD: v[16*lane[1] +: 16] = d[15:0];
            default: v = d;
        endcase
        return v;
    endfunction

    function automatic word_t read_value(reg_code_t code, size_t sz, logic sext);
        word_t src;
        if (code == CODE_SR) src = {16'd0, sr_word()};
        else if (code == CODE_FX) src = {24'd0, fbyte(alt)};
        else if (code[7]) src = ptr[code[3:2]] >> (8 * code[1:0]);
        else src = acc[{(code[6] ? rfp : code[5:4]), code[3:2]}] >> (8 * code[1:0]);
        case (sz)
            SZ_BYTE: return sext ? {{24{src[7]}}, src[7:0]} : {24'd0, src[7:0]};
            SZ_WORD: return sext ? {{16{src[15]}}, src[15:0]} : {16'd0, src[15:0]};
            default: return src;
        endcase
    endfunction

    task automatic apply_write(reg_code_t code, size_t sz, word_t d);
        logic [3:0] slot;
        if (code == CODE_FX) begin
            {flg, alt} = {alt, flg};                 // exchange sets
        end else if (code == CODE_SR) begin
            flg = {d[7], d[6], d[4], d[2], d[1], d[0]};
            if (sz == SZ_WORD) begin
                imask = d[14:12];
                rfp   = d[9:8];
            end
        end else if (code[7]) begin
            ptr[code[3:2]] = lane_merge(ptr[code[3:2]], sz, code[1:0], d);
        end else begin
            slot      = {(code[6] ? rfp : code[5:4]), code[3:2]};
            acc[slot] = lane_merge(acc[slot], sz, code[1:0], d);
        end
    endtask

    task automatic check_done();
        reg_code_t code;
        size_t     sz;
        logic      ok;
        word_t     exp;
        code = paddr[9:2];
        sz   = paddr[11:10];
        ok   = legal_xfer(code, sz, pwrite, pwdata);
        if (pslverr !== !ok) begin
            $display("Fail pslverr at paddr %h: got %h, expected %h", paddr, pslverr, !ok);
            value_errs++;
        end
        if (pwrite) begin
            writes++;
            if (waits != 0) begin
                $display("write at paddr %h took %0d wait states, expected none", paddr, waits);
                proto_errs++;
            end
            if (ok) apply_write(code, sz, pwdata);
        end else begin
            reads++;
            exp = ok ? read_value(code, sz, paddr[12]) : '0; // error reads give 0
            if (prdata !== exp) begin
                $display("Fail prdata at paddr %h: got %h, expected %h", paddr, prdata, exp);
                value_errs++;
            end
            if (waits != 1) begin
                $display("read at paddr %h took %0d wait states, expected one", paddr, waits);
                proto_errs++;
            end
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) acc[i] = '0;
            for (int i = 0; i < 4; i++) ptr[i] = '0;
            imask      = 3'd7;
            rfp        = 2'd0;
            flg        = '0;
            alt        = '0;
            waits      = 0;
            value_errs = 0;
            proto_errs = 0;
            reads      = 0;
            writes     = 0;
        end else if (psel && penable) begin
            if (!pready) begin
                waits++;                             // wait state
            end else begin
                check_done();
                waits = 0;
            end
        end
    end

endmodule

//--- dv/regs900_tb.sv
// random apb traffic into regs900_top from lfsr seed 47807; a cycle limit ends a stuck run
`timescale 1ns/1ps
module regs900_tb;
    import regs900_pkg::*;

    localparam int N_DIR   = 4;                      // reset value reads
    localparam int N_RAND  = 600;
    localparam int MAX_CYC = (N_DIR + N_RAND) * 3 + 200;

    logic              clk;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    word_t             pwdata;
    word_t             prdata;
    logic              pready;
    logic              pslverr;
    int                value_errs;
    int                proto_errs;
    int                reads;
    int                writes;
    int                cycles = 0;
    logic [15:0]       lfsr = 16'd47807;

    regs900_top dut_i (.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
                       .pready, .pslverr);

    regs900_checker chk_i (.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
                           .pready, .pslverr, .value_errs, .proto_errs, .reads, .writes);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic word_t rand_bits(int n);
        word_t v;
        logic  b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 16'hB400;
            v    = {v[30:0], b};
        end
        return v;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr, input word_t data);
        @(negedge clk);
        psel    = 1'b1;                              // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        do begin
            @(posedge clk);
        end while (!pready);
    endtask

    task automatic random_xfer();
        logic [3:0] kind;
        logic       wr;
        size_t      sz;
        logic [1:0] lane;
        logic [1:0] idx;
        logic [1:0] bank;
        logic       sext;
        word_t      data;
        reg_code_t  code;
        wr   = (rand_bits(2) != 0);                  // one read in four
        kind = 4'(rand_bits(4));
        sz   = size_t'(rand_bits(2));
        if (sz == SZ_ILL && rand_bits(2) != 0) sz = size_t'(rand_bits(1));
        lane = 2'(rand_bits(2));
        if (rand_bits(3) != 0) begin
            if (sz == SZ_LONG) lane = 2'd0;
            else if (sz == SZ_WORD) lane[0] = 1'b0;
        end
        idx  = 2'(rand_bits(2));
        bank = 2'(rand_bits(2));
        sext = 1'(rand_bits(1));
        data = rand_bits(32);
        if (kind <= 4'd8) begin
            code = {2'b00, bank, idx, lane};
        end else if (kind <= 4'd10) begin
            code = {2'b01, bank, idx, lane};         // current bank
        end else if (kind <= 4'd12) begin
            code = {4'b1000, idx, lane};             // pointer
        end else if (kind == 4'd13) begin
            code = CODE_SR;
            sz   = {1'b0, sz[0]};
        end else if (kind == 4'd14) begin
            code = CODE_FX;
            sz   = {1'b0, sz[0]};
            if (rand_bits(3) != 0) data = '0;
        end else begin
            code = 8'(rand_bits(8));                 // random code that is mostly illegal
        end
        apb_xfer(wr, {sext, sz, code, 2'b00}, data);
    endtask

    initial begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        apb_xfer(1'b0, {1'b0, SZ_WORD, CODE_SR, 2'b00}, '0);
        apb_xfer(1'b0, {1'b0, SZ_LONG, 8'h00, 2'b00}, '0);
        apb_xfer(1'b0, {1'b0, SZ_LONG, 4'b1000, 2'(XSP_IDX), 4'b0000}, '0); // stack pointer
        apb_xfer(1'b0, {1'b1, SZ_BYTE, CODE_FX, 2'b00}, '0);
        for (int i = 0; i < N_RAND; i++) begin
            random_xfer();
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        repeat (3) @(posedge clk);
        $display("errors: %0d value, %0d protocol; %0d reads and %0d writes checked",
                 value_errs, proto_errs, reads, writes);
        if (value_errs + proto_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYC) begin
            $display("timeout: transfers did not finish within %0d cycles", MAX_CYC);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

//--- logic/apb_reg_port.sv
// apb slave; writes finish with no wait state, reads with one; paddr must hold during a read
`timescale 1ns/1ps
module apb_reg_port (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [regs900_pkg::ADDR_W-1:0] paddr,
    input  regs900_pkg::word_t             pwdata,
    output regs900_pkg::word_t             prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic                           wr_en,
    output regs900_pkg::reg_code_t         wr_code,
    output regs900_pkg::size_t             wr_size,
    output regs900_pkg::word_t             wr_data,
    output regs900_pkg::rd_req_t           rd_req,
    input  regs900_pkg::word_t             rd_data
);
    import regs900_pkg::*;

    typedef enum logic {IDLE, RD_WAIT} state_t;

    state_t    state;
    reg_code_t code;
    size_t     size;
    logic      special;
    logic      illegal;
    logic      access;
    logic      rd_start;

    assign code     = paddr[9:2];
    assign size     = paddr[11:10];
    assign special  = code[7] & code[6];
    assign access   = psel & penable;
    assign rd_start = access & ~pwrite & (state == IDLE);

    always_comb begin
        illegal = (size == SZ_ILL);
        if (special && code != CODE_SR && code != CODE_FX) illegal = 1'b1; // unknown special
        if (special && size == SZ_LONG) illegal = 1'b1;
        if (!special && size == SZ_LONG && code[1:0] != 2'd0) illegal = 1'b1;
        if (!special && size == SZ_WORD && code[0]) illegal = 1'b1; // odd word lane
        if (code[7] && !code[6] && code[5:4] != 2'd0) illegal = 1'b1; // bad pointer code
        if (pwrite && code == CODE_FX && pwdata != '0) illegal = 1'b1;
    end

    assign pready  = (state == RD_WAIT) | (access & pwrite & (state == IDLE));
    assign pslverr = pready & illegal;

    assign wr_en   = access & pwrite & (state == IDLE) & ~illegal;
    assign wr_code = code;
    assign wr_size = size;
    assign wr_data = pwdata;
    assign rd_req  = '{code: code, size: size, sext: paddr[12]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            prdata <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (rd_start) begin
                        state  <= RD_WAIT;
                        prdata <= illegal ? '0 : rd_data; // error reads return 0
                    end
                end
                default: state <= IDLE;                     // wait state done
            endcase
        end
    end

endmodule

//--- logic/ctrl_regs.sv
// pointers, rfp, imask and both flag sets; a byte write to SR reaches the flags only
`timescale 1ns/1ps
module ctrl_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  regs900_pkg::ctrl_wr_t wr,
    output regs900_pkg::word_t    ptrs [regs900_pkg::N_PTR],
    output regs900_pkg::bank_t    rfp,
    output regs900_pkg::sr_t      sr,
    output regs900_pkg::flags_t   flags_alt
);
    import regs900_pkg::*;

    logic [2:0] imask;                               // interrupt mask
    flags_t     flags;                               // main set
    logic [1:0] pidx;

    assign pidx = wr.code[3:2];
    assign sr   = {1'b1, imask, 2'b10, rfp, flag_byte(flags)};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < N_PTR; i++) begin
                ptrs[i] <= '0;
            end
            rfp       <= '0;
            imask     <= 3'd7;                       // all interrupts masked
            flags     <= '0;
            flags_alt <= '0;
        end else if (we) begin
            if (wr.code == CODE_FX) begin
                flags     <= flags_alt;              // swap sets
                flags_alt <= flags;
            end else if (wr.code == CODE_SR) begin
                if (wr.lane_we[1]) begin
                    imask <= wr.data[14:12];
                    rfp   <= wr.data[9:8];
                end
                if (wr.lane_we[0]) begin
                    flags <= {wr.data[7:6], wr.data[4], wr.data[2:0]};
                end
            end else begin
                for (int l = 0; l < 4; l++) begin
                    if (wr.lane_we[l]) begin
                        ptrs[pidx][8*l +: 8] <= wr.data[8*l +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- logic/operand_mux.sv
// read path; specials are not lane shifted, unknown specials fall back to SR
`timescale 1ns/1ps
module operand_mux (
    input  regs900_pkg::rd_req_t req,
    input  regs900_pkg::bank_t   rfp,
    input  regs900_pkg::word_t   banks [regs900_pkg::N_BANKS][regs900_pkg::N_ACC],
    input  regs900_pkg::word_t   ptrs [regs900_pkg::N_PTR],
    input  regs900_pkg::sr_t     sr,
    input  regs900_pkg::flags_t  flags_alt,
    output regs900_pkg::word_t   data
);
    import regs900_pkg::*;

    bank_t      bank;
    logic       special;
    word_t      src;
    logic [4:0] shamt;
    word_t      aligned;

    assign special = req.code[7] & req.code[6];
    assign bank    = req.code[6] ? rfp : req.code[5:4]; // current bank via rfp

    always_comb begin
        if (special) begin
            if (req.code == CODE_FX) begin
                src = {24'd0, flag_byte(flags_alt)};
            end else begin
                src = {16'd0, sr};
            end
        end else if (req.code[7]) begin
            src = ptrs[req.code[3:2]];
        end else begin
            src = banks[bank][req.code[3:2]];
        end
    end

    // lane field picks the byte offset
    assign shamt   = special ? 5'd0 : {req.code[1:0], 3'b000};
    assign aligned = src >> shamt;

    always_comb begin
        case (req.size)
            SZ_BYTE: begin
                if (req.sext) begin
                    data = {{24{aligned[7]}}, aligned[7:0]};
                end else begin
                    data = {24'd0, aligned[7:0]};
                end
            end
            SZ_WORD: begin
                if (req.sext) begin
                    data = {{16{aligned[15]}}, aligned[15:0]};
                end else begin
                    data = {16'd0, aligned[15:0]};
                end
            end
            default: data = aligned;                 // long
        endcase
    end

endmodule

//--- logic/reg_bank.sv
// one accumulator bank; a write lands only when its bank field matches bank_id
`timescale 1ns/1ps
module reg_bank (
    input  logic                  clk,
    input  logic                  rst,
    input  regs900_pkg::bank_t    bank_id,
    input  logic                  we,
    input  regs900_pkg::bank_wr_t wr,
    output regs900_pkg::word_t    words [regs900_pkg::N_ACC]
);
    import regs900_pkg::*;

    logic hit;

    assign hit = we & (wr.bank == bank_id);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < N_ACC; i++) begin
                words[i] <= '0;
            end
        end else if (hit) begin
            for (int l = 0; l < 4; l++) begin
                if (wr.lane_we[l]) begin
                    words[wr.idx][8*l +: 8] <= wr.data[8*l +: 8]; // merge byte lane
                end
            end
        end
    end

endmodule

//--- logic/reg_write_ctrl.sv
// combinational write routing; expects only legal writes, size 3 enables no lane
`timescale 1ns/1ps
module reg_write_ctrl (
    input  logic                   wr_en,
    input  regs900_pkg::reg_code_t wr_code,
    input  regs900_pkg::size_t     wr_size,
    input  regs900_pkg::word_t     wr_data,
    input  regs900_pkg::bank_t     rfp,
    output regs900_pkg::bank_wr_t  bank_wr,
    output regs900_pkg::ctrl_wr_t  ctrl_wr,
    output logic                   bank_we,
    output logic                   ctrl_we
);
    import regs900_pkg::*;

    logic [1:0] lane;
    lane_en_t   lane_we;
    word_t      data;
    bank_t      bank;

    assign lane = wr_code[1:0];

    always_comb begin
        case (wr_size)
            SZ_BYTE: begin
                lane_we = lane_en_t'(4'b0001 << lane);
                data    = {4{wr_data[7:0]}};         // byte on every lane
            end
            SZ_WORD: begin
                lane_we = lane_en_t'(4'b0011 << {lane[1], 1'b0});
                data    = {2{wr_data[15:0]}};
            end
            SZ_LONG: begin
                lane_we = 4'b1111;
                data    = wr_data;
            end
            default: begin
                lane_we = 4'b0000;
                data    = wr_data;
            end
        endcase
    end

    // current-bank codes take rfp
    assign bank = wr_code[6] ? rfp : wr_code[5:4];

    assign bank_wr.bank    = bank;
    assign bank_wr.idx     = wr_code[3:2];
    assign bank_wr.lane_we = lane_we;
    assign bank_wr.data    = data;

    assign ctrl_wr.code    = wr_code;
    assign ctrl_wr.lane_we = lane_we;
    assign ctrl_wr.data    = data;

    assign bank_we = wr_en & ~wr_code[7];            // accumulators
    assign ctrl_we = wr_en & wr_code[7];             // pointers and specials

endmodule

//--- logic/regs900_pkg.sv
// shared types and codes; special codes are byte or word only, size 3 is never legal
package regs900_pkg;

    localparam int N_BANKS = 4;
    localparam int N_ACC   = 4;
    localparam int N_PTR   = 4;
    localparam int XSP_IDX = 3;                   // stack pointer slot
    localparam int ADDR_W  = 13;                  // apb address width

    typedef logic [31:0] word_t;
    typedef logic [7:0]  reg_code_t;
    typedef logic [1:0]  size_t;
    typedef logic [1:0]  bank_t;                  // bank number and rfp
    typedef logic [3:0]  lane_en_t;               // one bit per byte lane
    typedef logic [15:0] sr_t;

    localparam reg_code_t CODE_SR = 8'hF0;
    localparam reg_code_t CODE_FX = 8'hF1;

    localparam size_t SZ_BYTE = 2'd0;
    localparam size_t SZ_WORD = 2'd1;
    localparam size_t SZ_LONG = 2'd2;
    localparam size_t SZ_ILL  = 2'd3;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic v;
        logic n;
        logic c;
    } flags_t;

    typedef struct packed {
        bank_t    bank;
        logic [1:0] idx;
        lane_en_t lane_we;
        word_t    data;
    } bank_wr_t;

    typedef struct packed {
        reg_code_t code;
        size_t     size;
        logic      sext;
    } rd_req_t;

    typedef struct packed {
        reg_code_t code;
        lane_en_t  lane_we;
        word_t     data;
    } ctrl_wr_t;

    // flag byte layout with bits 5 and 3 held at 0
    function automatic logic [7:0] flag_byte(flags_t f);
        return {f.s, f.z, 1'b0, f.h, 1'b0, f.v, f.n, f.c};
    endfunction

endpackage

//--- logic/regs900_top.sv
// register file behind one apb slave; no core attached, the host does all access
`timescale 1ns/1ps
module regs900_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [regs900_pkg::ADDR_W-1:0] paddr,
    input  regs900_pkg::word_t             pwdata,
    output regs900_pkg::word_t             prdata,
    output logic                           pready,
    output logic                           pslverr
);
    import regs900_pkg::*;

    logic      wr_en;
    reg_code_t wr_code;
    size_t     wr_size;
    word_t     wr_data;
    rd_req_t   rd_req;
    word_t     rd_data;
    bank_wr_t  bank_wr;
    ctrl_wr_t  ctrl_wr;
    logic      bank_we;
    logic      ctrl_we;
    bank_t     rfp;
    sr_t       sr;
    flags_t    flags_alt;
    word_t     ptrs [N_PTR];
    word_t     bank_words [N_BANKS][N_ACC];

    apb_reg_port port_i (.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
                         .pready, .pslverr, .wr_en, .wr_code, .wr_size, .wr_data, .rd_req,
                         .rd_data);

    reg_write_ctrl wctl_i (.wr_en, .wr_code, .wr_size, .wr_data, .rfp, .bank_wr, .ctrl_wr,
                           .bank_we, .ctrl_we);

    for (genvar g = 0; g < N_BANKS; g++) begin : gen_bank
        reg_bank bank_i (.clk, .rst, .bank_id(bank_t'(g)), .we(bank_we), .wr(bank_wr),
                         .words(bank_words[g]));
    end

    ctrl_regs ctrl_i (.clk, .rst, .we(ctrl_we), .wr(ctrl_wr), .ptrs, .rfp, .sr, .flags_alt);

    operand_mux mux_i (.req(rd_req), .rfp, .banks(bank_words), .ptrs, .sr, .flags_alt,
                       .data(rd_data));

endmodule

//--- regs900.f
logic/regs900_pkg.sv
logic/apb_reg_port.sv
logic/reg_write_ctrl.sv
logic/reg_bank.sv
logic/ctrl_regs.sv
logic/operand_mux.sv
logic/regs900_top.sv
dv/regs900_checker.sv
dv/regs900_tb.sv
